//--- src/udp_gen_params.svh
`ifndef UDP_GEN_PARAMS_SVH
`define UDP_GEN_PARAMS_SVH

// Frame layout
`define UDP_PAYLOAD_SAMPLES 16
`define UDP_HDR_BYTES       42
`define UDP_FRAME_BYTES     (`UDP_HDR_BYTES + 2 * `UDP_PAYLOAD_SAMPLES)
`define UDP_BEATS           ((`UDP_FRAME_BYTES + 7) / 8)
`define UDP_LAST_KEEP       (8'hFF >> (8 * `UDP_BEATS - `UDP_FRAME_BYTES))

// Fixed header fields
`define UDP_SRC_MAC         48'h001A_2B3C_4D5E
`define UDP_ETHERTYPE       16'h0800
`define UDP_IP_VER_TOS      16'h4500
`define UDP_IP_TOTAL_LEN    16'(28 + 2 * `UDP_PAYLOAD_SAMPLES)
`define UDP_IP_ID           16'h0001
`define UDP_IP_FLAGS        16'h4000
`define UDP_IP_TTL_PROTO    16'hFF11
`define UDP_UDP_LEN         16'(8 + 2 * `UDP_PAYLOAD_SAMPLES)

// Values after reset
`define UDP_RST_DST_MAC     48'hFFFF_FFFF_FFFF
`define UDP_RST_SRC_IP      32'hC0A8_0463
`define UDP_RST_DST_IP      32'hC0A8_0401
`define UDP_RST_PORT        16'd60133
`define UDP_RST_DELAY       32'd10000000

// Register map
`define REG_SENT            6'h00
`define REG_TIMER           6'h04
`define REG_DELAY           6'h08
`define REG_MAC_LO          6'h0C
`define REG_MAC_HI          6'h10
`define REG_SRC_IP          6'h14
`define REG_DST_IP          6'h18
`define REG_SRC_PORT        6'h1C
`define REG_DST_PORT        6'h20

`endif

//--- src/udp_gen_pkg.sv
package udp_gen_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] csum_t;

    // Register port
    typedef logic [5:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Stream side
    typedef logic [63:0] beat_t;
    typedef logic [7:0]  keep_t;
    typedef logic [7:0]  beat_idx_t;
    typedef logic [31:0] count_t;

    // Programmable header fields
    typedef struct packed {
        mac_t     dst_mac;
        ip_addr_t src_ip;
        ip_addr_t dst_ip;
        port_t    src_port;
        port_t    dst_port;
    } udp_cfg_t;

    // Everything one frame needs, frozen at frame start
    typedef struct packed {
        udp_cfg_t cfg;
        csum_t    ip_csum;
    } frame_hdr_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_SUM,
        CS_FOLD
    } csum_state_t;

endpackage

//--- src/udp_cfg_regs.sv
`timescale 1ns/1ns
`include "udp_gen_params.svh"

module udp_cfg_regs import udp_gen_pkg::*; (
    input  logic      m00_axis_aclk,
    input  logic      s00_axi_aresetn,
    input  logic      reg_req,
    input  logic      reg_we,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    input  count_t    sent_count,
    input  count_t    timer,
    output logic      reg_ack,
    output reg_data_t reg_rdata,
    output udp_cfg_t  cfg,
    output count_t    delay,
    output logic      hdr_changed
);

    logic      access;
    logic      wr;
    logic      hdr_write;
    reg_data_t mac_lo_stage;   // Low MAC word waiting for the high half
    reg_data_t rd_mux;

    // One access per req, slave idle until req drops
    assign access = reg_req && !reg_ack;
    assign wr     = access && reg_we;

    // Addresses whose write alters the frame header
    always_comb begin
        case (reg_addr)
            `REG_MAC_HI,
            `REG_SRC_IP,
            `REG_DST_IP,
            `REG_SRC_PORT,
            `REG_DST_PORT: hdr_write = 1'b1;
            default:       hdr_write = 1'b0;
        endcase
    end

    always_comb begin
        case (reg_addr)
            `REG_SENT:     rd_mux = sent_count;
            `REG_TIMER:    rd_mux = timer;
            `REG_DELAY:    rd_mux = delay;
            `REG_MAC_LO:   rd_mux = cfg.dst_mac[31:0];   // Active MAC, not the staged word
            `REG_MAC_HI:   rd_mux = {16'h0000, cfg.dst_mac[47:32]};
            `REG_SRC_IP:   rd_mux = cfg.src_ip;
            `REG_DST_IP:   rd_mux = cfg.dst_ip;
            `REG_SRC_PORT: rd_mux = {16'h0000, cfg.src_port};
            `REG_DST_PORT: rd_mux = {16'h0000, cfg.dst_port};
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            reg_ack      <= 1'b0;
            reg_rdata    <= '0;
            hdr_changed  <= 1'b0;
            mac_lo_stage <= '0;
            delay        <= `UDP_RST_DELAY;
            cfg.dst_mac  <= `UDP_RST_DST_MAC;
            cfg.src_ip   <= `UDP_RST_SRC_IP;
            cfg.dst_ip   <= `UDP_RST_DST_IP;
            cfg.src_port <= `UDP_RST_PORT;
            cfg.dst_port <= `UDP_RST_PORT;
        end else begin
            hdr_changed <= wr && hdr_write;

            // Four-phase handshake
            if (access) begin
                reg_ack   <= 1'b1;
                reg_rdata <= rd_mux;
            end else if (reg_ack && !reg_req) begin
                reg_ack <= 1'b0;
            end

            if (wr) begin
                case (reg_addr)
                    `REG_DELAY:    delay        <= reg_wdata;
                    `REG_MAC_LO:   mac_lo_stage <= reg_wdata;
                    `REG_MAC_HI:   cfg.dst_mac  <= {reg_wdata[15:0], mac_lo_stage};
                    `REG_SRC_IP:   cfg.src_ip   <= reg_wdata;
                    `REG_DST_IP:   cfg.dst_ip   <= reg_wdata;
                    `REG_SRC_PORT: cfg.src_port <= reg_wdata[15:0];
                    `REG_DST_PORT: cfg.dst_port <= reg_wdata[15:0];
                    default: ;   // Read-only and unmapped
                endcase
            end
        end
    end

endmodule

//--- src/ip_checksum.sv
`timescale 1ns/1ns
`include "udp_gen_params.svh"

module ip_checksum import udp_gen_pkg::*; (
    input  logic     m00_axis_aclk,
    input  logic     s00_axi_aresetn,
    input  udp_cfg_t cfg,
    input  logic     hdr_changed,
    output csum_t    csum,
    output logic     csum_valid
);

    csum_state_t state;
    logic        init_q;     // Requests one sum right after reset
    logic        restart;
    logic [3:0]  word_idx;
    logic [31:0] acc;
    logic [15:0] word;
    logic [16:0] fold1;
    logic [15:0] fold2;

    assign restart = hdr_changed || init_q;

    // The ten IP header words in order
    always_comb begin
        case (word_idx)
            4'd0:    word = `UDP_IP_VER_TOS;
            4'd1:    word = `UDP_IP_TOTAL_LEN;
            4'd2:    word = `UDP_IP_ID;
            4'd3:    word = `UDP_IP_FLAGS;
            4'd4:    word = `UDP_IP_TTL_PROTO;
            4'd6:    word = cfg.src_ip[31:16];
            4'd7:    word = cfg.src_ip[15:0];
            4'd8:    word = cfg.dst_ip[31:16];
            4'd9:    word = cfg.dst_ip[15:0];
            default: word = 16'h0000;   // Word 5 is the checksum itself
        endcase
    end

    // Two end-around carries cover any sum of ten words
    assign fold1 = {1'b0, acc[31:16]} + {1'b0, acc[15:0]};
    assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            state      <= CS_IDLE;
            init_q     <= 1'b1;
            word_idx   <= '0;
            acc        <= '0;
            csum       <= '0;
            csum_valid <= 1'b0;
        end else begin
            init_q <= 1'b0;
            if (restart) begin
                state      <= CS_SUM;
                word_idx   <= '0;
                acc        <= '0;
                csum_valid <= 1'b0;
            end else begin
                case (state)
                    CS_SUM: begin
                        acc      <= acc + {16'h0000, word};
                        word_idx <= word_idx + 4'd1;
                        if (word_idx == 4'd9) state <= CS_FOLD;
                    end
                    CS_FOLD: begin
                        csum       <= ~fold2;
                        csum_valid <= 1'b1;
                        state      <= CS_IDLE;
                    end
                    default: state <= CS_IDLE;
                endcase
            end
        end
    end

endmodule

//--- src/frame_builder.sv
`timescale 1ns/1ns
`include "udp_gen_params.svh"

module frame_builder import udp_gen_pkg::*; (
    input  frame_hdr_t hdr,
    input  beat_idx_t  beat_idx,
    output beat_t      beat
);

    localparam int HDR_BYTES   = `UDP_HDR_BYTES;
    localparam int FRAME_BYTES = `UDP_FRAME_BYTES;

    // Header bytes in wire order, byte 0 in the top slot
    logic [HDR_BYTES-1:0][7:0] hdr_bytes;

    assign hdr_bytes = {
        hdr.cfg.dst_mac,
        `UDP_SRC_MAC,
        `UDP_ETHERTYPE,
        `UDP_IP_VER_TOS,
        `UDP_IP_TOTAL_LEN,
        `UDP_IP_ID,
        `UDP_IP_FLAGS,
        `UDP_IP_TTL_PROTO,
        hdr.ip_csum,
        hdr.cfg.src_ip,
        hdr.cfg.dst_ip,
        hdr.cfg.src_port,
        hdr.cfg.dst_port,
        `UDP_UDP_LEN,
        16'h0000                       // UDP checksum unused
    };

    always_comb begin
        logic [15:0] n;        // Absolute byte number in the frame
        logic [15:0] p;        // Byte number inside the payload
        logic [15:0] pair;     // Index j of the sample pair
        logic [15:0] sample;
        beat = '0;
        for (int lane = 0; lane < 8; lane++) begin
            n      = {8'h00, beat_idx} * 16'd8 + 16'(lane);
            p      = n - 16'(HDR_BYTES);
            pair   = p >> 2;
            // Even samples count up, odd ones count down from 255
            sample = p[1] ? (16'd255 - pair) : pair;
            if (n < 16'(HDR_BYTES)) begin
                beat[8*lane +: 8] = hdr_bytes[16'(HDR_BYTES - 1) - n];
            end else if (n < 16'(FRAME_BYTES)) begin
                beat[8*lane +: 8] = p[0] ? sample[15:8] : sample[7:0];   // Low byte first
            end else begin
                beat[8*lane +: 8] = 8'h00;
            end
        end
    end

endmodule

//--- src/axis_tx_ctrl.sv
`timescale 1ns/1ns
`include "udp_gen_params.svh"

module axis_tx_ctrl import udp_gen_pkg::*; (
    input  logic       m00_axis_aclk,
    input  logic       s00_axi_aresetn,
    input  count_t     delay,
    input  udp_cfg_t   cfg,
    input  csum_t      csum,
    input  logic       csum_valid,
    input  logic       m00_axis_tready,
    output frame_hdr_t hdr,
    output beat_idx_t  beat_idx,
    output logic       m00_axis_tvalid,
    output keep_t      m00_axis_tkeep,
    output logic       m00_axis_tlast,
    output count_t     sent_count,
    output count_t     timer
);

    localparam beat_idx_t LAST_IDX  = beat_idx_t'(`UDP_BEATS - 1);
    localparam keep_t     LAST_KEEP = keep_t'(`UDP_LAST_KEEP);

    tx_state_t state;
    logic      pending;
    logic      expire;
    logic      start;
    logic      xfer;
    beat_idx_t next_idx;
    udp_cfg_t  cfg_q;   // Lines up with csum, which lags a header write by a cycle

    assign expire   = (timer == delay) && (delay != '0);
    assign start    = pending && (state == TX_IDLE) && csum_valid;
    assign xfer     = m00_axis_tvalid && m00_axis_tready;
    assign next_idx = beat_idx + beat_idx_t'(1);

    // Interval timer and pending request
    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            timer   <= '0;
            pending <= 1'b0;
        end else begin
            timer <= expire ? '0 : timer + count_t'(1);
            if (delay == '0) pending <= 1'b0;   // Zero interval halts frames
            else if (expire) pending <= 1'b1;
            else if (start) pending <= 1'b0;
        end
    end

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            state           <= TX_IDLE;
            beat_idx        <= '0;
            m00_axis_tvalid <= 1'b0;
            m00_axis_tkeep  <= '0;
            m00_axis_tlast  <= 1'b0;
            sent_count      <= '0;
        end else begin
            case (state)
                TX_IDLE: if (start) begin
                    state           <= TX_SEND;
                    beat_idx        <= '0;
                    m00_axis_tvalid <= 1'b1;
                    m00_axis_tlast  <= 1'b0;    // Header alone spans several beats
                    m00_axis_tkeep  <= 8'hFF;
                end
                TX_SEND: if (xfer) begin
                    if (m00_axis_tlast) begin
                        state           <= TX_IDLE;
                        m00_axis_tvalid <= 1'b0;
                        m00_axis_tlast  <= 1'b0;
                        m00_axis_tkeep  <= '0;
                        sent_count      <= sent_count + count_t'(1);
                    end else begin
                        beat_idx       <= next_idx;
                        m00_axis_tlast <= (next_idx == LAST_IDX);
                        m00_axis_tkeep <= (next_idx == LAST_IDX) ? LAST_KEEP : 8'hFF;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Header snapshot held for the whole frame
    always_ff @(posedge m00_axis_aclk) begin
        cfg_q <= cfg;
        if (start) begin
            hdr.cfg     <= cfg_q;
            hdr.ip_csum <= csum;
        end
    end

endmodule

//--- src/udp_stream_top.sv
`timescale 1ns/1ns

module udp_stream_top import udp_gen_pkg::*; (
    input  logic      m00_axis_aclk,
    input  logic      s00_axi_aresetn,
    input  logic      reg_req,
    input  logic      reg_we,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    input  logic      m00_axis_tready,
    output logic      reg_ack,
    output reg_data_t reg_rdata,
    output logic      m00_axis_tvalid,
    output beat_t     m00_axis_tdata,
    output keep_t     m00_axis_tkeep,
    output logic      m00_axis_tlast
);

    udp_cfg_t   cfg;
    count_t     delay;
    logic       hdr_changed;
    csum_t      csum;
    logic       csum_valid;
    frame_hdr_t hdr;
    beat_idx_t  beat_idx;
    count_t     sent_count;
    count_t     timer;

    udp_cfg_regs regs_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .s00_axi_aresetn (s00_axi_aresetn),
        .reg_req         (reg_req),
        .reg_we          (reg_we),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .sent_count      (sent_count),
        .timer           (timer),
        .reg_ack         (reg_ack),
        .reg_rdata       (reg_rdata),
        .cfg             (cfg),
        .delay           (delay),
        .hdr_changed     (hdr_changed)
    );

    ip_checksum csum_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .s00_axi_aresetn (s00_axi_aresetn),
        .cfg             (cfg),
        .hdr_changed     (hdr_changed),
        .csum            (csum),
        .csum_valid      (csum_valid)
    );

    axis_tx_ctrl tx_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .s00_axi_aresetn (s00_axi_aresetn),
        .delay           (delay),
        .cfg             (cfg),
        .csum            (csum),
        .csum_valid      (csum_valid),
        .m00_axis_tready (m00_axis_tready),
        .hdr             (hdr),
        .beat_idx        (beat_idx),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tkeep  (m00_axis_tkeep),
        .m00_axis_tlast  (m00_axis_tlast),
        .sent_count      (sent_count),
        .timer           (timer)
    );

    frame_builder build_i (
        .hdr      (hdr),
        .beat_idx (beat_idx),
        .beat     (m00_axis_tdata)
    );

endmodule

//--- dv/tb_udp_stream.sv
`timescale 1ns/1ns
`include "udp_gen_params.svh"

module tb_udp_stream import udp_gen_pkg::*; ();

    localparam int SAMPLES     = `UDP_PAYLOAD_SAMPLES;
    localparam int FRAME_BYTES = 42 + 2 * SAMPLES;
    localparam int BEATS       = (FRAME_BYTES + 7) / 8;
    localparam int LAST_BYTES  = FRAME_BYTES - 8 * (BEATS - 1);
    localparam logic [7:0] LAST_KEEP = 8'((1 << LAST_BYTES) - 1);
    localparam int MAX_FRAMES  = 64;
    localparam int TIMEOUT     = 5000;   // Cycles per wait
    localparam int INTERVAL    = 300;

    logic      m00_axis_aclk = 1'b0;
    logic      s00_axi_aresetn;
    logic      reg_req;
    logic      reg_we;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    logic      m00_axis_tready = 1'b1;
    logic      reg_ack;
    reg_data_t reg_rdata;
    logic      m00_axis_tvalid;
    beat_t     m00_axis_tdata;
    keep_t     m00_axis_tkeep;
    logic      m00_axis_tlast;

    // Monitor state
    logic [7:0] rx_bytes [MAX_FRAMES][FRAME_BYTES];
    int         rx_count = 0;
    int         beat_num = 0;
    logic       ready_random = 1'b0;
    integer     seed = 11767;
    logic       stall_q = 1'b0;
    beat_t      data_q;
    keep_t      keep_q;
    logic       last_q;

    int         value_errors = 0;
    int         other_errors = 0;
    string      test_name = "reset";
    udp_cfg_t   exp_cfg;

    udp_stream_top dut_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .s00_axi_aresetn (s00_axi_aresetn),
        .reg_req         (reg_req),
        .reg_we          (reg_we),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .m00_axis_tready (m00_axis_tready),
        .reg_ack         (reg_ack),
        .reg_rdata       (reg_rdata),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tkeep  (m00_axis_tkeep),
        .m00_axis_tlast  (m00_axis_tlast)
    );

    initial begin
        forever #5 m00_axis_aclk = ~m00_axis_aclk;
    end

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("** Error [%s] %s: expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("Failure in %s: %s", test_name, msg);
    endtask

    // One four-phase transfer on the register port
    task automatic reg_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_data_t rdata);
        int cycles;
        @(negedge m00_axis_aclk);
        reg_req   = 1'b1;
        reg_we    = we;
        reg_addr  = addr;
        reg_wdata = wdata;
        cycles    = 0;
        while (!reg_ack && cycles < TIMEOUT) begin
            @(negedge m00_axis_aclk);
            cycles++;
        end
        if (!reg_ack) report_failure("register port never raised ack");
        rdata   = reg_rdata;
        reg_req = 1'b0;
        reg_we  = 1'b0;
        cycles  = 0;
        while (reg_ack && cycles < TIMEOUT) begin
            @(negedge m00_axis_aclk);
            cycles++;
        end
        if (reg_ack) report_failure("register port never dropped ack");
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_data_t unused;
        reg_access(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        reg_access(1'b0, addr, '0, data);
    endtask

    task automatic read_expect(input string what, input reg_addr_t addr, input reg_data_t exp);
        reg_data_t act;
        reg_read(addr, act);
        check_value(what, 64'(exp), 64'(act));
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (rx_count < target && cycles < TIMEOUT) begin
            @(negedge m00_axis_aclk);
            cycles++;
        end
        if (rx_count < target) begin
            report_failure($sformatf("only %0d of %0d frames arrived", rx_count, target));
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (m00_axis_tvalid && cycles < TIMEOUT) begin
            @(negedge m00_axis_aclk);
            cycles++;
        end
        if (m00_axis_tvalid) report_failure("stream never went idle");
    endtask

    // Ones' complement sum of the ten IP header words with the checksum word as zero
    function automatic logic [15:0] header_checksum(input udp_cfg_t c);
        logic [31:0] sum;
        sum = 32'h4500 + 32'(28 + 2 * SAMPLES) + 32'h0001 + 32'h4000 + 32'hFF11;
        sum = sum + 32'(c.src_ip[31:16]) + 32'(c.src_ip[15:0]);
        sum = sum + 32'(c.dst_ip[31:16]) + 32'(c.dst_ip[15:0]);
        while (sum[31:16] != 16'h0000) begin
            sum = 32'(sum[31:16]) + 32'(sum[15:0]);
        end
        return ~sum[15:0];
    endfunction

    function automatic logic [7:0] model_byte(input udp_cfg_t c, input int n);
        logic [8*42-1:0] hdr;   // Byte 0 at the top
        logic [15:0]     sample;
        int              k;
        hdr = {c.dst_mac, 48'h001A_2B3C_4D5E, 16'h0800,
               16'h4500, 16'(28 + 2 * SAMPLES), 16'h0001, 16'h4000, 16'hFF11,
               header_checksum(c), c.src_ip, c.dst_ip,
               c.src_port, c.dst_port, 16'(8 + 2 * SAMPLES), 16'h0000};
        if (n < 42) return hdr[8 * (41 - n) +: 8];
        k = (n - 42) / 2;
        sample = (k % 2 == 0) ? 16'(k / 2) : 16'(255 - k / 2);
        return ((n - 42) % 2 == 0) ? sample[7:0] : sample[15:8];   // Low byte first
    endfunction

    task automatic check_frame(input int idx, input udp_cfg_t c);
        if (idx >= rx_count || idx >= MAX_FRAMES) begin
            report_failure($sformatf("frame %0d is not available for comparison", idx));
        end else begin
            for (int n = 0; n < FRAME_BYTES; n++) begin
                check_value($sformatf("frame %0d byte %0d", idx, n),
                            64'(model_byte(c, n)), 64'(rx_bytes[idx][n]));
            end
        end
    endtask

    // Stream monitor that also drives tready
    always @(negedge m00_axis_aclk) begin : stream_monitor
        integer rnd;
        int     n;
        if (stall_q) begin
            check_value("held tvalid", 64'd1, 64'(m00_axis_tvalid));
            check_value("held tdata", data_q, m00_axis_tdata);
            check_value("held tkeep", 64'(keep_q), 64'(m00_axis_tkeep));
            check_value("held tlast", 64'(last_q), 64'(m00_axis_tlast));
        end
        rnd = $random(seed);
        m00_axis_tready = ready_random ? rnd[0] : 1'b1;
        if (m00_axis_tvalid && m00_axis_tready) begin   // Transfers at the next rising edge
            check_value("tlast", 64'(beat_num == BEATS - 1), 64'(m00_axis_tlast));
            check_value("tkeep", 64'((beat_num == BEATS - 1) ? LAST_KEEP : 8'hFF),
                        64'(m00_axis_tkeep));
            for (int lane = 0; lane < 8; lane++) begin
                n = 8 * beat_num + lane;
                if (n < FRAME_BYTES) begin
                    if (rx_count < MAX_FRAMES) rx_bytes[rx_count][n] = m00_axis_tdata[8*lane +: 8];
                end else begin
                    check_value("pad byte", 64'd0, 64'(m00_axis_tdata[8*lane +: 8]));
                end
            end
            if (m00_axis_tlast) begin
                rx_count++;
                beat_num = 0;
            end else begin
                beat_num++;
            end
        end
        stall_q = m00_axis_tvalid && !m00_axis_tready;
        data_q  = m00_axis_tdata;
        keep_q  = m00_axis_tkeep;
        last_q  = m00_axis_tlast;
    end

    initial begin
        int base;
        int busy;
        s00_axi_aresetn = 1'b0;
        reg_req         = 1'b0;
        reg_we          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        exp_cfg.dst_mac  = 48'hFFFF_FFFF_FFFF;
        exp_cfg.src_ip   = 32'hC0A8_0463;
        exp_cfg.dst_ip   = 32'hC0A8_0401;
        exp_cfg.src_port = 16'd60133;
        exp_cfg.dst_port = 16'd60133;
        repeat (2) @(posedge m00_axis_aclk);
        @(negedge m00_axis_aclk);
        s00_axi_aresetn = 1'b1;

        test_name = "reset defaults and readback";
        check_value("tvalid after reset", 64'd0, 64'(m00_axis_tvalid));
        check_value("tlast after reset", 64'd0, 64'(m00_axis_tlast));
        check_value("tkeep after reset", 64'd0, 64'(m00_axis_tkeep));
        check_value("ack after reset", 64'd0, 64'(reg_ack));
        read_expect("delay", `REG_DELAY, 32'd10000000);
        read_expect("mac lo", `REG_MAC_LO, 32'hFFFF_FFFF);
        read_expect("mac hi", `REG_MAC_HI, 32'h0000_FFFF);
        read_expect("src ip", `REG_SRC_IP, 32'hC0A8_0463);
        read_expect("dst ip", `REG_DST_IP, 32'hC0A8_0401);
        read_expect("src port", `REG_SRC_PORT, 32'd60133);
        read_expect("dst port", `REG_DST_PORT, 32'd60133);
        read_expect("sent", `REG_SENT, 32'd0);
        reg_write(`REG_SRC_PORT, 32'd5000);
        reg_write(`REG_DST_PORT, 32'd6000);
        exp_cfg.src_port = 16'd5000;
        exp_cfg.dst_port = 16'd6000;
        read_expect("src port", `REG_SRC_PORT, 32'd5000);
        read_expect("dst port", `REG_DST_PORT, 32'd6000);
        reg_write(`REG_SENT, 32'h0000_1234);   // Read-only
        read_expect("sent after write", `REG_SENT, 32'd0);
        read_expect("unmapped", 6'h24, 32'd0);

        test_name = "frame content";
        reg_write(`REG_DELAY, 32'(INTERVAL));
        read_expect("delay", `REG_DELAY, 32'(INTERVAL));
        base = rx_count;
        wait_frames(base + 3);
        for (int i = 0; i < 3; i++) check_frame(base + i, exp_cfg);

        test_name = "back-pressure";
        ready_random = 1'b1;
        base = rx_count;
        wait_frames(base + 3);
        for (int i = 0; i < 3; i++) check_frame(base + i, exp_cfg);

        test_name = "header update";
        wait_frames(rx_count + 1);   // Gap between frames
        reg_write(`REG_MAC_LO, 32'h3344_5566);
        read_expect("active mac lo", `REG_MAC_LO, exp_cfg.dst_mac[31:0]);
        base = rx_count;
        wait_frames(base + 1);
        check_frame(base, exp_cfg);
        reg_write(`REG_MAC_HI, 32'h0000_1122);
        reg_write(`REG_SRC_IP, 32'h0A00_0005);
        reg_write(`REG_DST_IP, 32'h0A00_00FE);
        reg_write(`REG_SRC_PORT, 32'd1111);
        reg_write(`REG_DST_PORT, 32'd2222);
        exp_cfg.dst_mac  = 48'h1122_3344_5566;
        exp_cfg.src_ip   = 32'h0A00_0005;
        exp_cfg.dst_ip   = 32'h0A00_00FE;
        exp_cfg.src_port = 16'd1111;
        exp_cfg.dst_port = 16'd2222;
        read_expect("mac hi", `REG_MAC_HI, 32'h0000_1122);
        read_expect("mac lo", `REG_MAC_LO, 32'h3344_5566);
        read_expect("src ip", `REG_SRC_IP, 32'h0A00_0005);
        read_expect("dst ip", `REG_DST_IP, 32'h0A00_00FE);
        base = rx_count;
        wait_frames(base + 1);
        check_frame(base, exp_cfg);

        test_name = "sent counter";
        reg_write(`REG_DELAY, 32'd0);
        wait_idle();
        busy = 0;
        repeat (2 * INTERVAL) begin
            @(negedge m00_axis_aclk);
            if (m00_axis_tvalid) busy++;
        end
        check_value("tvalid cycles after stop", 64'd0, 64'(busy));
        read_expect("sent", `REG_SENT, 32'(rx_count));

        $display("Closing: %0d frames, %0d value errors, %0d other failures",
                 rx_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/udp_gen_pkg.sv
src/udp_cfg_regs.sv
src/ip_checksum.sv
src/frame_builder.sv
src/axis_tx_ctrl.sv
src/udp_stream_top.sv
dv/tb_udp_stream.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_stream
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
